//--- compile.f
+incdir+verilog
+incdir+tb
verilog/scdPkg.sv
verilog/scadOperandSelect.sv
verilog/scadAlu.sv
verilog/scdRegisters.sv
verilog/pcFlags.sv
verilog/scdTop.sv
tb/tbScd.sv

//--- tb/tbScdVectors.svh
`ifndef TB_SCD_VECTORS_SVH
`define TB_SCD_VECTORS_SVH

// One row per microword with its inputs on the first line
// func, scada source, scadb source, sc source, ar, magic and ctrl
// ctrl holds from its high bit down feLoad feShift setAdFlags adOverflow adCry0 adCry1
// expTest pcfMagic loadFlags clrFpd
// The second line expects scad, scadSign and scadZero, then fe, sc and flags after the edge
task automatic loadVectors();
  // Reset state, then load FE with 12 and SC with 5
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h000, 1'b0, 1'b1, 10'h000, 10'h000, 7'h00);
  addRow(A, SelMagic, SelSc, ScHold, 36'h000000000, 9'h00C, 10'h200,
         10'h00C, 1'b0, 1'b0, 10'h00C, 10'h000, 7'h00);
  addRow(A, SelMagic, SelSc, ScFromScad, 36'h000000000, 9'h005, 10'h000,
         10'h005, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  // All eight functions with A = 12 and B = 5
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h00C, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(AMinusBMinus1, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h006, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(APlusB, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h011, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(AMinus1, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h00B, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(APlus1, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h00D, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(AMinusB, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h007, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(AOrB, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h00D, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(AAndB, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h004, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  // 12 - 20 goes negative and 12 - 12 is zero
  addRow(AMinusB, SelFe, SelMagicB, ScHold, 36'h000000000, 9'h014, 10'h000,
         10'h3F8, 1'b1, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(AMinusB, SelFe, SelMagicB, ScHold, 36'h000000000, 9'h00C, 10'h000,
         10'h000, 1'b0, 1'b1, 10'h00C, 10'h005, 7'h00);
  // Operand sources
  addRow(A, SelArPos, SelSc, ScHold, 36'hB40000000, 9'h000, 10'h000,
         10'h02D, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(A, SelArExp, SelSc, ScHold, 36'hC08000000, 9'h000, 10'h000,
         10'h07E, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(A, SelArExp, SelSc, ScHold, 36'h408000000, 9'h000, 10'h000,
         10'h081, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(A, SelMagic, SelSc, ScHold, 36'h000000000, 9'h1F0, 10'h000,
         10'h3F0, 1'b1, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(APlusB, SelZero, SelArSize, ScHold, 36'h03C000000, 9'h000, 10'h000,
         10'h03C, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  addRow(APlusB, SelZero, SelArHigh, ScHold, 36'hC08000000, 9'h000, 10'h000,
         10'h181, 1'b0, 1'b0, 10'h00C, 10'h005, 7'h00);
  // FE load, shift with sign fill, load over shift, SC sources
  addRow(A, SelMagic, SelSc, ScHold, 36'h000000000, 9'h1F0, 10'h200,
         10'h3F0, 1'b1, 1'b0, 10'h3F0, 10'h005, 7'h00);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h100,
         10'h3F0, 1'b1, 1'b0, 10'h3F8, 10'h005, 7'h00);
  addRow(A, SelMagic, SelSc, ScFromFe, 36'h000000000, 9'h003, 10'h300,
         10'h003, 1'b0, 1'b0, 10'h003, 10'h3F8, 7'h00);
  addRow(A, SelFe, SelSc, ScFromAr, 36'h000020081, 9'h000, 10'h000,
         10'h003, 1'b0, 1'b0, 10'h003, 10'h381, 7'h00);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h100,
         10'h003, 1'b0, 1'b0, 10'h001, 10'h381, 7'h00);
  // Flags load, sticky sets and FPD clear
  addRow(A, SelFe, SelSc, ScHold, 36'hA80800000, 9'h000, 10'h002,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h55);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h002,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h00);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h0D0,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h50);
  addRow(APlusB, SelZero, SelArHigh, ScHold, 36'h800000000, 9'h000, 10'h008,
         10'h100, 1'b0, 1'b0, 10'h001, 10'h381, 7'h58);
  addRow(A, SelMagic, SelSc, ScHold, 36'h000000000, 9'h100, 10'h008,
         10'h300, 1'b1, 1'b0, 10'h001, 10'h381, 7'h5A);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h044, 10'h004,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h5F);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h001,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h5B);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h040, 10'h005,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h5F);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h108, 10'h0A4,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h7F);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h000,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h7F);
  // Magic sets OV, FOV and FXU on cleared flags while the adder carries stay gated off
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h000, 10'h002,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h00);
  addRow(A, SelFe, SelSc, ScHold, 36'h000000000, 9'h108, 10'h074,
         10'h001, 1'b0, 1'b0, 10'h001, 10'h381, 7'h4A);
endtask

`endif

//--- tb/tbScd.sv
`timescale 1ns/10ps
`default_nettype none

module tbScd;

  import scdPkg::*;

  typedef struct {
    scadFuncE func;
    scadaSelE aSel;
    scadbSelE bSel;
    scSelE scSel;
    wordT ar;
    magicT magic;
    logic [9:0] ctrl;
    scadT expScad;
    logic expSign;
    logic expZero;
    scadT expFe;
    scadT expSc;
    pcFlagsT expFlags;
  } rowT;

  logic clk = 1'b0;
  logic arstN;
  scadFuncE scadFunc;
  scadaSelE scadaSel;
  scadbSelE scadbSel;
  scSelE scSel;
  wordT ar;
  magicT magic;
  logic feLoad;
  logic feShift;
  logic setAdFlags;
  logic adOverflow;
  logic adCry0;
  logic adCry1;
  logic expTest;
  logic pcfMagic;
  logic loadFlags;
  logic clrFpd;
  scadT scad;
  logic scadSign;
  logic scadZero;
  scadT fe;
  scadT sc;
  pcFlagsT flags;

  rowT rows[$];

  scdTop i_dut (
    .clk        (clk),
    .arstN      (arstN),
    .scadFunc   (scadFunc),
    .scadaSel   (scadaSel),
    .scadbSel   (scadbSel),
    .scSel      (scSel),
    .ar         (ar),
    .magic      (magic),
    .feLoad     (feLoad),
    .feShift    (feShift),
    .setAdFlags (setAdFlags),
    .adOverflow (adOverflow),
    .adCry0     (adCry0),
    .adCry1     (adCry1),
    .expTest    (expTest),
    .pcfMagic   (pcfMagic),
    .loadFlags  (loadFlags),
    .clrFpd     (clrFpd),
    .scad       (scad),
    .scadSign   (scadSign),
    .scadZero   (scadZero),
    .fe         (fe),
    .sc         (sc),
    .flags      (flags)
  );

  always #50 clk = ~clk;

  task automatic addRow(input scadFuncE func, input scadaSelE aSel, input scadbSelE bSel,
                        input scSelE scS, input wordT arIn, input magicT magicIn,
                        input logic [9:0] ctrl, input scadT expScad, input logic expSign,
                        input logic expZero, input scadT expFe, input scadT expSc,
                        input pcFlagsT expFlags);
    rowT r;
    r.func = func;
    r.aSel = aSel;
    r.bSel = bSel;
    r.scSel = scS;
    r.ar = arIn;
    r.magic = magicIn;
    r.ctrl = ctrl;
    r.expScad = expScad;
    r.expSign = expSign;
    r.expZero = expZero;
    r.expFe = expFe;
    r.expSc = expSc;
    r.expFlags = expFlags;
    rows.push_back(r);
  endtask

  `include "tbScdVectors.svh"

  task automatic stopOnError(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic checkScad(input string what, input scadT got, input scadT exp);
    if (got !== exp) begin
      stopOnError(what, got, exp);
    end
  endtask

  task automatic checkFlags(input string what, input pcFlagsT got, input pcFlagsT exp);
    if (got !== exp) begin
      stopOnError(what, got, exp);
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError(what, got, exp);
    end
  endtask

  // Polls the clock until it reaches the wanted level from the other one
  task automatic waitEdge(input logic level);
    logic last;
    bit seen;
    int steps;
    last = clk;
    seen = 0;
    for (steps = 0; steps < 200 && !seen; steps++) begin
      #1;
      if (clk === level && last !== level) begin
        seen = 1;
      end
      last = clk;
    end
    if (!seen) begin
      $display("Timeout: the clock stopped toggling while the testbench waited for an edge");
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  initial begin
    rowT r;
    arstN = 1'b0;
    scadFunc = A;
    scadaSel = SelFe;
    scadbSel = SelSc;
    scSel = ScHold;
    ar = '0;
    magic = '0;
    {feLoad, feShift, setAdFlags, adOverflow, adCry0, adCry1} = '0;
    {expTest, pcfMagic, loadFlags, clrFpd} = '0;
    loadVectors();

    waitEdge(1'b1);
    waitEdge(1'b1);
    waitEdge(1'b0);
    arstN = 1'b1;
    checkScad("fe after reset", fe, '0);
    checkScad("sc after reset", sc, '0);
    checkFlags("flags after reset", flags, '0);

    foreach (rows[i]) begin
      r = rows[i];
      scadFunc = r.func;
      scadaSel = r.aSel;
      scadbSel = r.bSel;
      scSel = r.scSel;
      ar = r.ar;
      magic = r.magic;
      {feLoad, feShift, setAdFlags, adOverflow, adCry0, adCry1,
       expTest, pcfMagic, loadFlags, clrFpd} = r.ctrl;
      #10;
      checkScad($sformatf("row %0d scad", i), scad, r.expScad);
      checkBit($sformatf("row %0d scadSign", i), scadSign, r.expSign);
      checkBit($sformatf("row %0d scadZero", i), scadZero, r.expZero);
      waitEdge(1'b1);
      waitEdge(1'b0);
      checkScad($sformatf("row %0d fe", i), fe, r.expFe);
      checkScad($sformatf("row %0d sc", i), sc, r.expSc);
      checkFlags($sformatf("row %0d flags", i), flags, r.expFlags);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/pcFlags.sv
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module pcFlags (
  input  wire               clk,
  input  wire               arstN,
  input  wire               loadFlags,
  input  wire               setAdFlags,
  input  wire               adOverflow,
  input  wire               adCry0,
  input  wire               adCry1,
  input  wire               expTest,
  input  wire               pcfMagic,
  input  wire               clrFpd,
  input  wire scdPkg::wordT  ar,
  input  wire scdPkg::magicT magic,
  input  wire scdPkg::scadT  scad,
  output scdPkg::pcFlagsT    flags
);

  import scdPkg::*;

  pcFlagsT arFlags;
  pcFlagsT setFlags;
  pcFlagsT flagsNext;
  logic expOverflow;
  logic expUnderflow;
  logic magicFov;

  // Exponent test looks at the two high SCAD bits
  assign expOverflow = expTest & scad[`SCD_SCAD_IDX(1)];
  assign expUnderflow = expTest & scad[`SCD_SCAD_IDX(0)];
  assign magicFov = pcfMagic & magic[`SCD_MAGIC_IDX(0)];

  always_comb begin
    arFlags[`SCD_FLAG_OV] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_OV)];
    arFlags[`SCD_FLAG_CRY0] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_CRY0)];
    arFlags[`SCD_FLAG_CRY1] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_CRY1)];
    arFlags[`SCD_FLAG_FOV] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_FOV)];
    arFlags[`SCD_FLAG_FPD] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_FPD)];
    arFlags[`SCD_FLAG_FXU] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_FXU)];
    arFlags[`SCD_FLAG_DIVCHK] = ar[`SCD_AR_IDX(`SCD_AR_FLAG_DIVCHK)];
  end

  always_comb begin
    setFlags[`SCD_FLAG_OV] = (setAdFlags & adOverflow) | expOverflow | magicFov;
    setFlags[`SCD_FLAG_CRY0] = setAdFlags & adCry0;
    setFlags[`SCD_FLAG_CRY1] = setAdFlags & adCry1;
    setFlags[`SCD_FLAG_FOV] = expOverflow | magicFov;
    setFlags[`SCD_FLAG_FPD] = pcfMagic & magic[`SCD_MAGIC_IDX(2)];
    setFlags[`SCD_FLAG_FXU] = expUnderflow | (pcfMagic & magic[`SCD_MAGIC_IDX(5)]);
    setFlags[`SCD_FLAG_DIVCHK] = pcfMagic & magic[`SCD_MAGIC_IDX(6)];
  end

  always_comb begin
    if (loadFlags) begin
      flagsNext = arFlags;
    end else begin
      flagsNext = flags | setFlags;
      // A set of FPD in the same cycle wins over the clear
      flagsNext[`SCD_FLAG_FPD] = (flags[`SCD_FLAG_FPD] & ~clrFpd)
                               | setFlags[`SCD_FLAG_FPD];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

endmodule

`default_nettype wire

//--- verilog/scadAlu.sv
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scadAlu (
  input  wire scdPkg::scadFuncE scadFunc,
  input  wire scdPkg::scadT     scada,
  input  wire scdPkg::scadT     scadb,
  output scdPkg::scadT          scad,
  output logic                  scadSign,
  output logic                  scadZero
);

  import scdPkg::*;

  // One guard bit above SCAD bit 0 so the sign survives an overflow
  logic [`SCD_SCAD_WIDTH:0] aExt;
  logic [`SCD_SCAD_WIDTH:0] bExt;
  logic [`SCD_SCAD_WIDTH:0] result;

  assign aExt = {scada[`SCD_SCAD_IDX(0)], scada};
  assign bExt = {scadb[`SCD_SCAD_IDX(0)], scadb};

  always_comb begin
    case (scadFunc)
      A: begin
        result = aExt;
      end
      AMinusBMinus1: begin
        // Same as A plus the ones complement of B with no carry in
        result = aExt + ~bExt;
      end
      APlusB: begin
        result = aExt + bExt;
      end
      AMinus1: begin
        result = aExt - 1'b1;
      end
      APlus1: begin
        result = aExt + 1'b1;
      end
      AMinusB: begin
        result = aExt - bExt;
      end
      AOrB: begin
        result = aExt | bExt;
      end
      AAndB: begin
        result = aExt & bExt;
      end
      default: begin
        result = aExt;
      end
    endcase
  end

  // The low ten bits wrap modulo 1024
  assign scad = result[`SCD_SCAD_WIDTH-1:0];
  assign scadSign = result[`SCD_SCAD_WIDTH];
  assign scadZero = (scad == '0);

endmodule

`default_nettype wire

//--- verilog/scadOperandSelect.sv
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scadOperandSelect (
  input  wire scdPkg::scadaSelE scadaSel,
  input  wire scdPkg::scadbSelE scadbSel,
  input  wire scdPkg::wordT     ar,
  input  wire scdPkg::magicT    magic,
  input  wire scdPkg::scadT     fe,
  input  wire scdPkg::scadT     sc,
  output scdPkg::scadT          scada,
  output scdPkg::scadT          scadb
);

  import scdPkg::*;

  localparam int expWidth = `SCD_AR_EXP_LAST - `SCD_AR_EXP_FIRST + 1;
  localparam int sizeWidth = `SCD_AR_SIZE_LAST - `SCD_AR_SIZE_FIRST + 1;
  localparam int posWidth = 6;

  logic [expWidth-1:0] arExp;
  logic [sizeWidth-1:0] arSize;
  logic [posWidth-1:0] arPos;
  logic [`SCD_MAGIC_WIDTH-1:0] arHigh;
  logic magicSign;

  // A negative word holds its exponent in ones complement, so flip it back
  assign arExp = ar[`SCD_AR_IDX(`SCD_AR_EXP_FIRST):`SCD_AR_IDX(`SCD_AR_EXP_LAST)]
               ^ {expWidth{ar[`SCD_AR_IDX(0)]}};

  assign arSize = ar[`SCD_AR_IDX(`SCD_AR_SIZE_FIRST):`SCD_AR_IDX(`SCD_AR_SIZE_LAST)];

  // Byte position field in AR bits 0 to 5
  assign arPos = ar[`SCD_AR_IDX(0):`SCD_AR_IDX(posWidth-1)];

  assign arHigh = ar[`SCD_AR_IDX(0):`SCD_AR_IDX(`SCD_MAGIC_WIDTH-1)];

  assign magicSign = magic[`SCD_MAGIC_IDX(0)];

  always_comb begin
    case (scadaSel)
      SelFe: begin
        scada = fe;
      end
      SelArPos: begin
        scada = {{(`SCD_SCAD_WIDTH-posWidth){1'b0}}, arPos};
      end
      SelArExp: begin
        scada = {{(`SCD_SCAD_WIDTH-expWidth){1'b0}}, arExp};
      end
      SelMagic: begin
        // Magic bit 0 is repeated into SCAD bit 0 as a sign
        scada = {magicSign, magic};
      end
      default: begin
        scada = '0;
      end
    endcase
  end

  always_comb begin
    case (scadbSel)
      SelSc: begin
        scadb = sc;
      end
      SelArSize: begin
        scadb = {{(`SCD_SCAD_WIDTH-sizeWidth){1'b0}}, arSize};
      end
      SelArHigh: begin
        scadb = {1'b0, arHigh};
      end
      default: begin
        scadb = {1'b0, magic};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/scdPkg.sv
`default_nettype none

`include "scd_cfg.svh"

package scdPkg;

  typedef logic [`SCD_SCAD_WIDTH-1:0] scadT;
  typedef logic [`SCD_WORD_WIDTH-1:0] wordT;
  typedef logic [`SCD_MAGIC_WIDTH-1:0] magicT;
  typedef logic [`SCD_FLAG_COUNT-1:0] pcFlagsT;

  // Adder function in the encoding of the microword SCAD field
  typedef enum logic [2:0] {
    A             = 3'd0,
    AMinusBMinus1 = 3'd1,
    APlusB        = 3'd2,
    AMinus1       = 3'd3,
    APlus1        = 3'd4,
    AMinusB       = 3'd5,
    AOrB          = 3'd6,
    AAndB         = 3'd7
  } scadFuncE;

  // Codes 5 to 7 select zero as well
  typedef enum logic [2:0] {
    SelFe    = 3'd0,
    SelArPos = 3'd1,
    SelArExp = 3'd2,
    SelMagic = 3'd3,
    SelZero  = 3'd4
  } scadaSelE;

  typedef enum logic [1:0] {
    SelSc     = 2'd0,
    SelArSize = 2'd1,
    SelArHigh = 2'd2,
    SelMagicB = 2'd3
  } scadbSelE;

  typedef enum logic [1:0] {
    ScHold     = 2'd0,
    ScFromFe   = 2'd1,
    ScFromScad = 2'd2,
    ScFromAr   = 2'd3
  } scSelE;

endpackage

`default_nettype wire

//--- verilog/scdRegisters.sv
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scdRegisters (
  input  wire                clk,
  input  wire                arstN,
  input  wire                feLoad,
  input  wire                feShift,
  input  wire scdPkg::scSelE scSel,
  input  wire scdPkg::scadT  scad,
  input  wire scdPkg::wordT  ar,
  output scdPkg::scadT       fe,
  output scdPkg::scadT       sc
);

  import scdPkg::*;

  localparam int scLowWidth = `SCD_AR_SC_LAST - `SCD_AR_SC_FIRST + 1;

  scadT feNext;
  scadT scNext;
  scadT scFromArValue;
  logic arScSign;

  // AR bit 18 fills both high SC bits and the rest comes from AR bits 28 to 35
  assign arScSign = ar[`SCD_AR_IDX(`SCD_AR_SC_SIGN)];
  assign scFromArValue = {
    {(`SCD_SCAD_WIDTH-scLowWidth){arScSign}},
    ar[`SCD_AR_IDX(`SCD_AR_SC_FIRST):`SCD_AR_IDX(`SCD_AR_SC_LAST)]
  };

  always_comb begin
    if (feLoad) begin
      feNext = scad;
    end else if (feShift) begin
      // Arithmetic right shift that keeps the sign in bit 0
      feNext = {fe[`SCD_SCAD_IDX(0)], fe[`SCD_SCAD_WIDTH-1:1]};
    end else begin
      feNext = fe;
    end
  end

  always_comb begin
    case (scSel)
      ScFromFe: begin
        scNext = fe;
      end
      ScFromScad: begin
        scNext = scad;
      end
      ScFromAr: begin
        scNext = scFromArValue;
      end
      default: begin
        scNext = sc;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fe <= '0;
      sc <= '0;
    end else begin
      fe <= feNext;
      sc <= scNext;
    end
  end

endmodule

`default_nettype wire

//--- verilog/scdTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scdTop (
  input  wire                   clk,
  input  wire                   arstN,
  input  wire scdPkg::scadFuncE scadFunc,
  input  wire scdPkg::scadaSelE scadaSel,
  input  wire scdPkg::scadbSelE scadbSel,
  input  wire scdPkg::scSelE    scSel,
  input  wire scdPkg::wordT     ar,
  input  wire scdPkg::magicT    magic,
  input  wire                   feLoad,
  input  wire                   feShift,
  input  wire                   setAdFlags,
  input  wire                   adOverflow,
  input  wire                   adCry0,
  input  wire                   adCry1,
  input  wire                   expTest,
  input  wire                   pcfMagic,
  input  wire                   loadFlags,
  input  wire                   clrFpd,
  output scdPkg::scadT          scad,
  output logic                  scadSign,
  output logic                  scadZero,
  output scdPkg::scadT          fe,
  output scdPkg::scadT          sc,
  output scdPkg::pcFlagsT       flags
);

  import scdPkg::*;

  scadT scada;
  scadT scadb;

  scadOperandSelect i_scadOperandSelect (
    .scadaSel (scadaSel),
    .scadbSel (scadbSel),
    .ar       (ar),
    .magic    (magic),
    .fe       (fe),
    .sc       (sc),
    .scada    (scada),
    .scadb    (scadb)
  );

  scadAlu i_scadAlu (
    .scadFunc (scadFunc),
    .scada    (scada),
    .scadb    (scadb),
    .scad     (scad),
    .scadSign (scadSign),
    .scadZero (scadZero)
  );

  scdRegisters i_scdRegisters (
    .clk     (clk),
    .arstN   (arstN),
    .feLoad  (feLoad),
    .feShift (feShift),
    .scSel   (scSel),
    .scad    (scad),
    .ar      (ar),
    .fe      (fe),
    .sc      (sc)
  );

  pcFlags i_pcFlags (
    .clk        (clk),
    .arstN      (arstN),
    .loadFlags  (loadFlags),
    .setAdFlags (setAdFlags),
    .adOverflow (adOverflow),
    .adCry0     (adCry0),
    .adCry1     (adCry1),
    .expTest    (expTest),
    .pcfMagic   (pcfMagic),
    .clrFpd     (clrFpd),
    .ar         (ar),
    .magic      (magic),
    .scad       (scad),
    .flags      (flags)
  );

endmodule

`default_nettype wire

//--- verilog/scd_cfg.svh
`ifndef SCD_CFG_SVH
`define SCD_CFG_SVH

// Datapath widths
`define SCD_SCAD_WIDTH 10
`define SCD_WORD_WIDTH 36
`define SCD_MAGIC_WIDTH 9
`define SCD_FLAG_COUNT 7

// Machine bit n sits at vector index width-1-n
`define SCD_AR_IDX(n) (`SCD_WORD_WIDTH - 1 - (n))
`define SCD_SCAD_IDX(n) (`SCD_SCAD_WIDTH - 1 - (n))
`define SCD_MAGIC_IDX(n) (`SCD_MAGIC_WIDTH - 1 - (n))

// Positions inside the flag vector
`define SCD_FLAG_OV 6
`define SCD_FLAG_CRY0 5
`define SCD_FLAG_CRY1 4
`define SCD_FLAG_FOV 3
`define SCD_FLAG_FPD 2
`define SCD_FLAG_FXU 1
`define SCD_FLAG_DIVCHK 0

// AR bit each flag loads from
`define SCD_AR_FLAG_OV 0
`define SCD_AR_FLAG_CRY0 1
`define SCD_AR_FLAG_CRY1 2
`define SCD_AR_FLAG_FOV 3
`define SCD_AR_FLAG_FPD 4
`define SCD_AR_FLAG_FXU 11
`define SCD_AR_FLAG_DIVCHK 12

// AR fields used by the SCAD operand and SC muxes
`define SCD_AR_EXP_FIRST 1
`define SCD_AR_EXP_LAST 8
`define SCD_AR_SIZE_FIRST 6
`define SCD_AR_SIZE_LAST 11
`define SCD_AR_SC_SIGN 18
`define SCD_AR_SC_FIRST 28
`define SCD_AR_SC_LAST 35

`endif
